//--- Makefile
# verilator build, run, lint and clean for the geometry front end testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module tb_torsion
	@out="$$(./obj_dir/Vtb_torsion 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module tb_torsion

clean:
	rm -rf obj_dir

//--- build.f
+incdir+design
design/md_pkg.sv
design/pos_fetch.sv
design/term_fifo.sv
design/torsion_geom.sv
design/torsion_top.sv
sim/torsion_sva.sv
sim/tb_torsion.sv

//--- design/md_params.svh
// md geometry front end: coordinate, id, buffer and arithmetic sizes
`ifndef MD_PARAMS_SVH
`define MD_PARAMS_SVH

// signed fixed-point position coordinate
`define COORD_W 10

// particle id, also the position table address
`define PID_W 4
`define TABLE_DEPTH (1 << `PID_W)

// term records held between fetch and geometry engine
`define FIFO_DEPTH 4

// bond vector component, one bit over a coordinate
`define DIFF_W 11
// plane normal component, sum of two diff products
`define CROSS_W 23
// r23 x a component
`define C_W 35
// dot product, sum of three c by b products
`define DOT_W 60

`endif

//--- design/md_pkg.sv
// md geometry types: packet word, term record, result record
`include "md_params.svh"

package md_pkg;

    // packet type in the top two bits, other codes are ignored
    typedef enum logic [1:0] {
        BOND    = 2'd1,
        TORSION = 2'd3
    } term_kind_e;

    typedef struct packed {
        logic signed [`COORD_W-1:0] x;
        logic signed [`COORD_W-1:0] y;
        logic signed [`COORD_W-1:0] z;
    } vec_t;

    // torsion view, four ids and a short tag
    typedef struct packed {
        term_kind_e          kind;
        logic [`PID_W-1:0]   id1;
        logic [`PID_W-1:0]   id2;
        logic [`PID_W-1:0]   id3;
        logic [`PID_W-1:0]   id4;
        logic [7:0]          tag;
    } tors_view_t;

    // bond view, two ids, the freed id bits widen the tag
    typedef struct packed {
        term_kind_e          kind;
        logic [`PID_W-1:0]   id1;
        logic [`PID_W-1:0]   id2;
        logic [15:0]         tag;
    } bond_view_t;

    typedef union packed {
        tors_view_t tors;
        bond_view_t bond;
    } term_pkt_u;

    // fifo payload, positions already looked up
    typedef struct packed {
        term_kind_e          kind;
        logic [15:0]         tag;
        logic [`PID_W-1:0]   id1;
        logic [`PID_W-1:0]   id2;
        logic [`PID_W-1:0]   id3;
        logic [`PID_W-1:0]   id4;
        vec_t                pos1;
        vec_t                pos2;
        vec_t                pos3;
        vec_t                pos4;
    } term_rec_t;

    typedef struct packed {
        term_kind_e                 kind;
        logic [15:0]                tag;
        logic [`PID_W-1:0]          id1;
        logic [`PID_W-1:0]          id2;
        logic [`PID_W-1:0]          id3;
        logic [`PID_W-1:0]          id4;
        logic signed [`DOT_W-1:0]   cos_num;
        logic signed [`DOT_W-1:0]   sin_num;
    } geom_res_t;

endpackage

//--- design/pos_fetch.sv
// position fetch: local position table, packet decode, term record push
`include "md_params.svh"

module pos_fetch
    import md_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pos_we,
    input  logic [`PID_W-1:0] pos_addr,
    input  vec_t              pos_data,
    input  logic              pkt_valid,
    input  term_pkt_u         pkt,
    output logic              push,
    output term_rec_t         rec
);

    vec_t      pos_tab [`TABLE_DEPTH];
    term_rec_t rec_nxt;
    logic      push_nxt;

    // table starts at zero, a write lands at the edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                pos_tab[i] <= '0;
            end
        end else if (pos_we) begin
            pos_tab[pos_addr] <= pos_data;
        end
    end

    // kind sits at the top of both views
    always_comb begin
        rec_nxt  = '0;
        push_nxt = 1'b0;
        if (pkt_valid) begin
            case (pkt.tors.kind)
                TORSION: begin
                    push_nxt     = 1'b1;
                    rec_nxt.kind = TORSION;
                    rec_nxt.tag  = {8'd0, pkt.tors.tag};
                    rec_nxt.id1  = pkt.tors.id1;
                    rec_nxt.id2  = pkt.tors.id2;
                    rec_nxt.id3  = pkt.tors.id3;
                    rec_nxt.id4  = pkt.tors.id4;
                    rec_nxt.pos1 = pos_tab[pkt.tors.id1];
                    rec_nxt.pos2 = pos_tab[pkt.tors.id2];
                    rec_nxt.pos3 = pos_tab[pkt.tors.id3];
                    rec_nxt.pos4 = pos_tab[pkt.tors.id4];
                end
                BOND: begin
                    // ids 3 and 4 and their positions stay zero
                    push_nxt     = 1'b1;
                    rec_nxt.kind = BOND;
                    rec_nxt.tag  = pkt.bond.tag;
                    rec_nxt.id1  = pkt.bond.id1;
                    rec_nxt.id2  = pkt.bond.id2;
                    rec_nxt.pos1 = pos_tab[pkt.bond.id1];
                    rec_nxt.pos2 = pos_tab[pkt.bond.id2];
                end
                default: begin
                    // unknown kind, nothing pushed
                    push_nxt = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push <= 1'b0;
        end else begin
            push <= push_nxt;
        end
    end

    // payload only, qualified by push
    always_ff @(posedge clk) begin
        rec <= rec_nxt;
    end

endmodule

//--- design/term_fifo.sv
// term record buffer between fetch and geometry engine, sticky overflow
`include "md_params.svh"

module term_fifo
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      push,
    input  term_rec_t din,
    input  logic      pop,
    output term_rec_t head,
    output logic      empty,
    output logic      overflow
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    term_rec_t        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;

    assign full    = (count == CNT_W'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    // a push into a full buffer is dropped
    assign do_push = push && !full;
    // oldest entry straight from the storage registers
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // consumer only pops when not empty
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // held until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- design/torsion_geom.sv
// iterative geometry engine: bond vectors, shared cross unit, cos/sin numerators
`include "md_params.svh"

module torsion_geom
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      empty,
    input  term_rec_t head,
    output logic      pop,
    output logic      res_valid,
    output geom_res_t res
);

    typedef enum logic [2:0] {
        IDLE, DIFF, CROSS_A, CROSS_B, CROSS_C, DOT
    } geom_state_e;

    geom_state_e state;
    geom_state_e state_nxt;
    term_rec_t   rec_q;

    // component order x, y, z
    logic signed [`DIFF_W-1:0]  r12 [3];
    logic signed [`DIFF_W-1:0]  r23 [3];
    logic signed [`DIFF_W-1:0]  r34 [3];
    logic signed [`CROSS_W-1:0] a_q [3];
    logic signed [`CROSS_W-1:0] b_q [3];
    logic signed [`C_W-1:0]     c_q [3];

    // shared cross unit operands and result
    logic signed [`DIFF_W-1:0]  cu [3];
    logic signed [`CROSS_W-1:0] cv [3];
    logic signed [`C_W-1:0]     cross_out [3];
    logic signed [`DOT_W-1:0]   cos_sum;
    logic signed [`DOT_W-1:0]   sin_sum;

    // free again in the result cycle
    assign pop       = ((state == IDLE) || (state == DOT)) && !empty;
    assign res_valid = (state == DOT);

    always_comb begin
        case (state)
            IDLE, DOT: state_nxt = empty ? IDLE : DIFF;
            // bond skips the cross steps
            DIFF:      state_nxt = (rec_q.kind == BOND) ? DOT : CROSS_A;
            CROSS_A:   state_nxt = CROSS_B;
            CROSS_B:   state_nxt = CROSS_C;
            CROSS_C:   state_nxt = DOT;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // a = r12 x r23, b = r23 x r34, c = r23 x a
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            case (state)
                CROSS_B: begin
                    cu[i] = r23[i];
                    cv[i] = `CROSS_W'(r34[i]);
                end
                CROSS_C: begin
                    cu[i] = r23[i];
                    cv[i] = a_q[i];
                end
                default: begin
                    cu[i] = r12[i];
                    cv[i] = `CROSS_W'(r23[i]);
                end
            endcase
        end
        cross_out[0] = `C_W'(cu[1]) * `C_W'(cv[2]) - `C_W'(cu[2]) * `C_W'(cv[1]);
        cross_out[1] = `C_W'(cu[2]) * `C_W'(cv[0]) - `C_W'(cu[0]) * `C_W'(cv[2]);
        cross_out[2] = `C_W'(cu[0]) * `C_W'(cv[1]) - `C_W'(cu[1]) * `C_W'(cv[0]);
    end

    always_ff @(posedge clk) begin
        // record latched together with the pop
        if (pop) begin
            rec_q <= head;
        end
        case (state)
            DIFF: begin
                // later position minus earlier one
                r12[0] <= `DIFF_W'(rec_q.pos2.x) - `DIFF_W'(rec_q.pos1.x);
                r12[1] <= `DIFF_W'(rec_q.pos2.y) - `DIFF_W'(rec_q.pos1.y);
                r12[2] <= `DIFF_W'(rec_q.pos2.z) - `DIFF_W'(rec_q.pos1.z);
                r23[0] <= `DIFF_W'(rec_q.pos3.x) - `DIFF_W'(rec_q.pos2.x);
                r23[1] <= `DIFF_W'(rec_q.pos3.y) - `DIFF_W'(rec_q.pos2.y);
                r23[2] <= `DIFF_W'(rec_q.pos3.z) - `DIFF_W'(rec_q.pos2.z);
                r34[0] <= `DIFF_W'(rec_q.pos4.x) - `DIFF_W'(rec_q.pos3.x);
                r34[1] <= `DIFF_W'(rec_q.pos4.y) - `DIFF_W'(rec_q.pos3.y);
                r34[2] <= `DIFF_W'(rec_q.pos4.z) - `DIFF_W'(rec_q.pos3.z);
            end
            CROSS_A: begin
                // a fits in the narrower normal width
                for (int i = 0; i < 3; i++) begin
                    a_q[i] <= cross_out[i][`CROSS_W-1:0];
                end
            end
            CROSS_B: begin
                for (int i = 0; i < 3; i++) begin
                    b_q[i] <= cross_out[i][`CROSS_W-1:0];
                end
            end
            CROSS_C: begin
                for (int i = 0; i < 3; i++) begin
                    c_q[i] <= cross_out[i];
                end
            end
            default: begin
            end
        endcase
    end

    // torsion: a.b and c.b, bond: |r12|^2 and zero
    always_comb begin
        cos_sum = '0;
        sin_sum = '0;
        for (int i = 0; i < 3; i++) begin
            if (rec_q.kind == BOND) begin
                cos_sum = cos_sum + `DOT_W'(r12[i]) * `DOT_W'(r12[i]);
            end else begin
                cos_sum = cos_sum + `DOT_W'(a_q[i]) * `DOT_W'(b_q[i]);
                sin_sum = sin_sum + `DOT_W'(c_q[i]) * `DOT_W'(b_q[i]);
            end
        end
    end

    always_comb begin
        res.kind    = rec_q.kind;
        res.tag     = rec_q.tag;
        res.id1     = rec_q.id1;
        res.id2     = rec_q.id2;
        res.id3     = rec_q.id3;
        res.id4     = rec_q.id4;
        res.cos_num = cos_sum;
        res.sin_num = sin_sum;
    end

endmodule

//--- design/torsion_top.sv
// bonded-term geometry front end: fetch, term buffer and geometry engine
`include "md_params.svh"

module torsion_top
    import md_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // position table load
    input  logic              pos_we,
    input  logic [`PID_W-1:0] pos_addr,
    input  vec_t              pos_data,
    // term packets, one per strobe
    input  logic              pkt_valid,
    input  term_pkt_u         pkt,
    // results, no back-pressure
    output logic              res_valid,
    output geom_res_t         res,
    output logic              overflow
);

    logic      push;
    term_rec_t rec;
    logic      empty;
    term_rec_t head;
    logic      pop;

    pos_fetch u_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .pos_we    (pos_we),
        .pos_addr  (pos_addr),
        .pos_data  (pos_data),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .push      (push),
        .rec       (rec)
    );

    // absorbs bursts while the engine works one term at a time
    term_fifo u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .din      (rec),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .overflow (overflow)
    );

    torsion_geom u_geom (
        .clk       (clk),
        .arst_n    (arst_n),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

//--- sim/tb_torsion.sv
// testbench for the geometry front end: random terms checked against a reference model
`include "md_params.svh"

module tb_torsion
    import md_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // packet bits below the kind field
    localparam int BODY_W = $bits(term_pkt_u) - 2;

    logic              clk;
    logic              arst_n;
    logic              pos_we;
    logic [`PID_W-1:0] pos_addr;
    vec_t              pos_data;
    logic              pkt_valid;
    term_pkt_u         pkt;
    logic              res_valid;
    geom_res_t         res;
    logic              overflow;

    // own copy of the position table
    vec_t        pos_model [`TABLE_DEPTH];
    geom_res_t   exp_q [$];
    logic [31:0] lfsr;
    int          n_res;
    // set during the burst, refused packets may be skipped
    bit          skip_ok;

    torsion_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .pos_we    (pos_we),
        .pos_addr  (pos_addr),
        .pos_data  (pos_data),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .res_valid (res_valid),
        .res       (res),
        .overflow  (overflow)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic vec_t rand_vec();
        vec_t        v;
        logic [31:0] b;
        b = rand_bits(`COORD_W);
        v.x = b[`COORD_W-1:0];
        b = rand_bits(`COORD_W);
        v.y = b[`COORD_W-1:0];
        b = rand_bits(`COORD_W);
        v.z = b[`COORD_W-1:0];
        return v;
    endfunction

    // ids and tag share the body bits in both packet views
    function automatic term_pkt_u rand_pkt(input term_kind_e kind);
        logic [31:0] b;
        b = rand_bits(BODY_W);
        return {kind, b[BODY_W-1:0]};
    endfunction

    function automatic longint comp(input vec_t v, input int i);
        case (i)
            0:       return longint'(v.x);
            1:       return longint'(v.y);
            default: return longint'(v.z);
        endcase
    endfunction

    function automatic longint det2(input longint a, input longint b,
                                    input longint c, input longint d);
        return a * d - b * c;
    endfunction

    // expected result from the packet and the current table copy
    function automatic geom_res_t ref_result(input term_pkt_u p);
        geom_res_t r;
        vec_t      q [4];
        longint    d12 [3];
        longint    d23 [3];
        longint    d34 [3];
        longint    a [3];
        longint    b [3];
        longint    c [3];
        longint    cos_v;
        longint    sin_v;
        r = '0;
        if (p.tors.kind == TORSION) begin
            q[0] = pos_model[p.tors.id1];
            q[1] = pos_model[p.tors.id2];
            q[2] = pos_model[p.tors.id3];
            q[3] = pos_model[p.tors.id4];
            r.kind = TORSION;
            r.tag = {8'd0, p.tors.tag};
            r.id1 = p.tors.id1;
            r.id2 = p.tors.id2;
            r.id3 = p.tors.id3;
            r.id4 = p.tors.id4;
        end else begin
            // bond: ids 3 and 4 stay zero
            q[0] = pos_model[p.bond.id1];
            q[1] = pos_model[p.bond.id2];
            q[2] = '0;
            q[3] = '0;
            r.kind = BOND;
            r.tag = p.bond.tag;
            r.id1 = p.bond.id1;
            r.id2 = p.bond.id2;
        end
        // later position minus earlier one
        for (int i = 0; i < 3; i++) begin
            d12[i] = comp(q[1], i) - comp(q[0], i);
            d23[i] = comp(q[2], i) - comp(q[1], i);
            d34[i] = comp(q[3], i) - comp(q[2], i);
        end
        // a = r12 x r23, b = r23 x r34
        for (int i = 0; i < 3; i++) begin
            a[i] = det2(d12[(i+1)%3], d12[(i+2)%3], d23[(i+1)%3], d23[(i+2)%3]);
            b[i] = det2(d23[(i+1)%3], d23[(i+2)%3], d34[(i+1)%3], d34[(i+2)%3]);
        end
        // c = r23 x a
        for (int i = 0; i < 3; i++) begin
            c[i] = det2(d23[(i+1)%3], d23[(i+2)%3], a[(i+1)%3], a[(i+2)%3]);
        end
        cos_v = 0;
        sin_v = 0;
        for (int i = 0; i < 3; i++) begin
            if (r.kind == BOND) begin
                cos_v = cos_v + d12[i] * d12[i];
            end else begin
                cos_v = cos_v + a[i] * b[i];
                sin_v = sin_v + c[i] * b[i];
            end
        end
        r.cos_num = cos_v[`DOT_W-1:0];
        r.sin_num = sin_v[`DOT_W-1:0];
        return r;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] want);
        if (got !== want) begin
            fail_now($sformatf("FAILED %s got %h expected %h", name, got, want));
        end
    endtask

    task automatic compare_result(input geom_res_t got, input geom_res_t want);
        check_val("res.kind", 64'(got.kind), 64'(want.kind));
        check_val("res.tag", 64'(got.tag), 64'(want.tag));
        check_val("res.id1", 64'(got.id1), 64'(want.id1));
        check_val("res.id2", 64'(got.id2), 64'(want.id2));
        check_val("res.id3", 64'(got.id3), 64'(want.id3));
        check_val("res.id4", 64'(got.id4), 64'(want.id4));
        check_val("res.cos_num", 64'(got.cos_num), 64'(want.cos_num));
        check_val("res.sin_num", 64'(got.sin_num), 64'(want.sin_num));
    endtask

    // one cycle of inputs, driven on the falling edge
    task automatic drive_cycle(input logic we, input logic [`PID_W-1:0] addr,
                               input vec_t data, input logic pv, input term_pkt_u p);
        @(negedge clk);
        pos_we    = we;
        pos_addr  = addr;
        pos_data  = data;
        pkt_valid = pv;
        pkt       = p;
        // the packet reads the table before this cycle's write lands
        if (pv && ((p.tors.kind == TORSION) || (p.tors.kind == BOND))) begin
            exp_q.push_back(ref_result(p));
        end
        if (we) begin
            pos_model[addr] = data;
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            pos_we    = 1'b0;
            pkt_valid = 1'b0;
        end
    endtask

    task automatic send_pkt(input term_pkt_u p, input int gap);
        drive_cycle(1'b0, '0, '0, 1'b1, p);
        idle(gap);
    endtask

    // until every expected result has come back
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0) && (cycles < 200)) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            fail_now("timeout: expected results still pending");
        end
    endtask

    // until no result has appeared for 8 cycles
    task automatic wait_quiet();
        int cycles;
        int quiet;
        cycles = 0;
        quiet = 0;
        while ((quiet < 8) && (cycles < 300)) begin
            @(negedge clk);
            cycles++;
            quiet = res_valid ? 0 : quiet + 1;
        end
        if (quiet < 8) begin
            fail_now("timeout: result stream did not go quiet");
        end
    endtask

    initial begin : compare_results
        geom_res_t got;
        geom_res_t want;
        bit        found;
        forever begin
            @(negedge clk);
            if (arst_n && res_valid) begin
                got = res;
                n_res++;
                if (exp_q.size() == 0) begin
                    fail_now("result strobe with no packet pending");
                end else if (skip_ok) begin
                    // accepted terms are an in-order subsequence of those sent
                    found = 1'b0;
                    while (!found && (exp_q.size() != 0)) begin
                        want = exp_q.pop_front();
                        found = (want == got);
                    end
                    if (!found) begin
                        fail_now("burst result matches no pending packet");
                    end
                end else begin
                    want = exp_q.pop_front();
                    compare_result(got, want);
                end
            end
        end
    end

    initial begin : stimulus
        term_pkt_u   p;
        vec_t        v;
        logic [31:0] b;
        int          n0;
        lfsr      = 32'hfad1;
        n_res     = 0;
        skip_ok   = 1'b0;
        arst_n    = 1'b1;
        pos_we    = 1'b0;
        pos_addr  = '0;
        pos_data  = '0;
        pkt_valid = 1'b0;
        pkt       = '0;
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            pos_model[i] = '0;
        end
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // quiet after reset
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_val("res_valid", 64'(res_valid), 64'd0);
            check_val("overflow", 64'(overflow), 64'd0);
        end

        // random table contents
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            drive_cycle(1'b1, `PID_W'(i), rand_vec(), 1'b0, '0);
        end
        idle(1);

        // spaced torsions
        for (int k = 0; k < 8; k++) begin
            send_pkt(rand_pkt(TORSION), 6);
        end
        wait_drain();

        // bonds, then unknown kinds that must stay silent
        for (int k = 0; k < 6; k++) begin
            send_pkt(rand_pkt(BOND), 3);
        end
        wait_drain();
        send_pkt(rand_pkt(term_kind_e'(2'd0)), 2);
        send_pkt(rand_pkt(term_kind_e'(2'd2)), 2);
        idle(12);

        // mixed stream, order kept
        for (int k = 0; k < 12; k++) begin
            b = rand_bits(1);
            send_pkt(rand_pkt(b[0] ? TORSION : BOND), 3);
        end
        wait_drain();
        check_val("overflow", 64'(overflow), 64'd0);

        // rewrite a cycle ahead of the packet, new value is used
        p = {TORSION, `PID_W'(5), `PID_W'(6), `PID_W'(7), `PID_W'(8), 8'h5a};
        v = rand_vec();
        drive_cycle(1'b1, `PID_W'(5), v, 1'b0, '0);
        drive_cycle(1'b0, '0, '0, 1'b1, p);
        idle(1);
        wait_drain();
        // rewrite in the packet cycle, old value is used
        v = rand_vec();
        drive_cycle(1'b1, `PID_W'(6), v, 1'b1, p);
        idle(1);
        wait_drain();
        send_pkt(p, 1);
        wait_drain();

        // back-to-back burst overruns the buffer
        skip_ok = 1'b1;
        n0 = n_res;
        for (int k = 0; k < 12; k++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, rand_pkt(TORSION));
        end
        idle(1);
        wait_quiet();
        check_val("overflow", 64'(overflow), 64'd1);
        if ((n_res - n0) >= 12) begin
            fail_now("burst of 12 gave a result for every packet despite overflow");
        end
        // an empty buffer takes at least a full load before refusing
        if ((n_res - n0) < `FIFO_DEPTH) begin
            fail_now("burst gave fewer results than the buffer holds");
        end
        // a later term flushes the refused entries from the queue
        send_pkt(rand_pkt(TORSION), 1);
        wait_drain();
        skip_ok = 1'b0;
        idle(4);

        if (u_dut.u_sva.err_count != 0) begin
            $display("assertion failures: %0d", u_dut.u_sva.err_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures seen");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- sim/torsion_sva.sv
// interface assertions on the term buffer and geometry engine wires
`include "md_params.svh"

module torsion_sva
    import md_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input logic      pop,
    input logic      empty,
    input logic      overflow,
    input logic      res_valid,
    input geom_res_t res
);

    timeunit 1ns;
    timeprecision 1ps;

    // failures seen so far, read by the testbench at the end
    int err_count = 0;

    // engine only takes a record that is present
    pop_needs_entry: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> !empty
    ) else begin
        $error("pop while the term buffer is empty");
        err_count++;
    end

    // a torsion result is a single-cycle strobe
    tors_result_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        (res_valid && (res.kind == TORSION)) |=> !res_valid
    ) else begin
        $error("torsion result strobe held for two cycles");
        err_count++;
    end

    // overflow only clears through reset
    overflow_sticky: assert property (
        @(posedge clk) disable iff (!arst_n) overflow |=> overflow
    ) else begin
        $error("overflow fell outside reset");
        err_count++;
    end

    // nothing moves while reset is held
    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!res_valid && !pop && !overflow && empty)
    ) else begin
        $error("activity while reset is asserted");
        err_count++;
    end

endmodule

// buffer and engine meet in the top level, so the checker sits there
bind torsion_top torsion_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .pop       (pop),
    .empty     (empty),
    .overflow  (overflow),
    .res_valid (res_valid),
    .res       (res)
);
